/* build.f */
+incdir+design
+incdir+verif
design/soc_pkg.sv
design/addr_decoder.sv
design/boot_rom.sv
design/sram_mem.sv
design/debug_gate.sv
design/soc_top.sv
verif/soc_tb.sv

/* design/addr_decoder.sv */
/*
  Routes master requests to the boot ROM or the SRAM, one request in flight.
  Response comes one cycle after acceptance; ROM writes and unmapped
  addresses return DECERR with zero data.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module addr_decoder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Master request
  input  logic                   req_valid_i,
  input  soc_pkg::bus_req_t      req_i,
  output logic                   req_ready_o,
  // Master response
  output logic                   rsp_valid_o,
  output soc_pkg::bus_rsp_t      rsp_o,
  input  logic                   rsp_ready_i,
  // Memory side
  output logic                   rom_sel_o,
  output logic                   sram_sel_o,
  output soc_pkg::bus_req_t      mem_req_o,
  input  logic [`SOC_DATA_W-1:0] rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0] sram_rdata_i
);

  localparam logic [`SOC_ADDR_W-1:0] rom_lo  = `SOC_ROM_BASE;
  localparam logic [`SOC_ADDR_W-1:0] rom_hi  = `SOC_ROM_BASE + `SOC_ROM_LEN;
  localparam logic [`SOC_ADDR_W-1:0] sram_lo = `SOC_DRAM_BASE;
  localparam logic [`SOC_ADDR_W-1:0] sram_hi = `SOC_DRAM_BASE + `SOC_SRAM_LEN;

  logic              accept;
  logic              rom_hit;
  logic              sram_hit;
  soc_pkg::region_e  region_d;
  soc_pkg::region_e  region_q;
  logic              busy_q;       // Memory access in its read cycle
  logic              read_q;
  logic              rsp_valid_q;
  soc_pkg::bus_rsp_t rsp_d;
  soc_pkg::bus_rsp_t rsp_q;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  assign req_ready_o = !busy_q && !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  assign rom_hit  = (req_i.addr >= rom_lo) && (req_i.addr < rom_hi);
  assign sram_hit = (req_i.addr >= sram_lo) && (req_i.addr < sram_hi);

  always_comb begin
    region_d = soc_pkg::REG_NONE;
    if (sram_hit) begin
      region_d = soc_pkg::REG_SRAM;
    end else if (rom_hit && req_i.op == soc_pkg::OP_READ) begin
      region_d = soc_pkg::REG_ROM;    // ROM is read-only
    end
  end

  // One-cycle strobes, request goes out unchanged
  assign rom_sel_o  = accept && (region_d == soc_pkg::REG_ROM);
  assign sram_sel_o = accept && (region_d == soc_pkg::REG_SRAM);
  assign mem_req_o  = req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      region_q    <= soc_pkg::REG_NONE;
      read_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      busy_q <= accept;
      if (accept) begin
        region_q <= region_d;
        read_q   <= (req_i.op == soc_pkg::OP_READ);
      end
      if (busy_q) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;      // Handshake done
      end
    end
  end

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.resp  = soc_pkg::RESP_OKAY;
    case (region_q)
      soc_pkg::REG_ROM: begin
        rsp_d.rdata = rom_rdata_i;
      end
      soc_pkg::REG_SRAM: begin
        if (read_q) begin
          rsp_d.rdata = sram_rdata_i;   // Write data from SRAM ignored
        end
      end
      default: begin
        rsp_d.resp = soc_pkg::RESP_DECERR;
      end
    endcase
  end

  // Sampled in the memory's read cycle, held until taken
  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("Response changed or dropped under back-pressure");

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_sel_o && sram_sel_o))
    else $error("ROM and SRAM selected together");

endmodule

/* design/boot_rom.sv */
/*
  Boot ROM with one-cycle registered read.
  The address must fall inside the ROM region when selected.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module boot_rom (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   sel_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int unsigned off_lsb = $clog2(`SOC_BE_W);
  localparam int unsigned idx_w   = $clog2(`SOC_ROM_WORDS);

  logic [`SOC_ADDR_W-1:0] word_off;
  logic [idx_w-1:0]       idx;
  logic [`SOC_DATA_W-1:0] rdata_q;

  // Word offset within the region
  assign word_off = (addr_i - `SOC_ROM_BASE) >> off_lsb;
  assign idx      = word_off[idx_w-1:0];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= soc_pkg::rom_image[idx];
    end
  end

  assign rdata_o = rdata_q;

  // Decoder keeps out-of-region accesses away
  a_idx_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_i |-> word_off < `SOC_ROM_WORDS)
    else $error("ROM selected outside its region");

endmodule

/* design/debug_gate.sv */
/*
  Holds per-hart debug requests low for SOC_DBG_DELAY cycles after reset,
  so boot code runs first. Requests stay low while debug is disabled.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module debug_gate (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dbg_enable_i,
  input  logic [`SOC_NB_HARTS-1:0] debug_req_i,
  output logic [`SOC_NB_HARTS-1:0] debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`SOC_DBG_DELAY + 1);

  logic [cnt_w-1:0] cnt_q;

  // Down counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= cnt_w'(`SOC_DBG_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0 && dbg_enable_i) ? debug_req_i : '0;

  a_quiet_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q != '0 |-> debug_req_o == '0)
    else $error("Debug request leaked during the post-reset window");

endmodule

/* design/soc_config.svh */
/*
  Widths, address map and timing constants of the memory subsystem.
  Region bases must be aligned to the data word size.
*/
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define SOC_ADDR_W     32
`define SOC_DATA_W     64
`define SOC_BE_W       (`SOC_DATA_W / 8)

// ----------------------------------------------------------
// Address map
// ----------------------------------------------------------
`define SOC_ROM_BASE   32'h0001_0000
`define SOC_ROM_WORDS  16
`define SOC_ROM_LEN    (`SOC_ROM_WORDS * `SOC_BE_W)    // Bytes
`define SOC_DRAM_BASE  32'h8000_0000
`define SOC_SRAM_WORDS 256
`define SOC_SRAM_LEN   (`SOC_SRAM_WORDS * `SOC_BE_W)   // Bytes
// Last word of the SRAM region
`define SOC_EXIT_ADDR  (`SOC_DRAM_BASE + `SOC_SRAM_LEN - `SOC_BE_W)

// ----------------------------------------------------------
// Debug
// ----------------------------------------------------------
`define SOC_NB_HARTS   2
`define SOC_DBG_DELAY  20   // Cycles after reset release

`endif

/* design/soc_pkg.sv */
/*
  Bus request and response types, enums and the boot image.
  The boot image holds exactly SOC_ROM_WORDS words.
*/
`include "soc_config.svh"

package soc_pkg;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  typedef enum logic {
    RESP_OKAY,
    RESP_DECERR
  } bus_resp_e;

  // Target of the transfer in flight
  typedef enum logic [1:0] {
    REG_NONE,   // Unmapped or illegal, answered with an error
    REG_ROM,
    REG_SRAM
  } region_e;

  typedef struct packed {
    bus_op_e                op;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_BE_W-1:0]   be;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    bus_resp_e              resp;
  } bus_rsp_t;

  // Boot image, word 0 at SOC_ROM_BASE
  localparam logic [`SOC_DATA_W-1:0] rom_image [`SOC_ROM_WORDS] = '{
    64'h0000_0297_0282_8293, 64'hf140_2573_0202_85b3,
    64'h0182_b283_0002_8067, 64'h1050_0073_ffdf_f06f,
    64'h8000_0000_0000_0000, 64'h0000_0000_0001_0040,
    64'h00c5_8593_0010_0513, 64'h3020_0073_3410_1073,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5555_aaaa_3333_cccc,
    64'h0f0f_0f0f_f0f0_f0f0, 64'h0000_0001_0000_0002,
    64'h7fff_ffff_8000_0001, 64'h0000_0000_0000_0073
  };

endpackage

/* design/soc_top.sv */
/*
  Memory subsystem top: decoder, boot ROM, SRAM and debug gate.
  Single bus master, one transfer in flight.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Master port
  input  logic                     req_valid_i,
  input  soc_pkg::bus_req_t        req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  output soc_pkg::bus_rsp_t        rsp_o,
  input  logic                     rsp_ready_i,
  // Test exit value
  output logic [`SOC_DATA_W-1:0]   exit_o,
  // Debug
  input  logic                     dbg_enable_i,
  input  logic [`SOC_NB_HARTS-1:0] debug_req_i,
  output logic [`SOC_NB_HARTS-1:0] debug_req_o
);

  logic                   rom_sel;
  logic                   sram_sel;
  soc_pkg::bus_req_t      mem_req;
  logic [`SOC_DATA_W-1:0] rom_rdata;
  logic [`SOC_DATA_W-1:0] sram_rdata;

  // ----------------------------------------------------------
  // Bus
  // ----------------------------------------------------------
  addr_decoder i_addr_decoder (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .req_valid_i  ( req_valid_i ),
    .req_i        ( req_i       ),
    .req_ready_o  ( req_ready_o ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_o        ( rsp_o       ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rom_sel_o    ( rom_sel     ),
    .sram_sel_o   ( sram_sel    ),
    .mem_req_o    ( mem_req     ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .sel_i   ( rom_sel      ),
    .addr_i  ( mem_req.addr ),
    .rdata_o ( rom_rdata    )
  );

  sram_mem i_sram_mem (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .sel_i   ( sram_sel   ),
    .req_i   ( mem_req    ),
    .rdata_o ( sram_rdata ),
    .exit_o  ( exit_o     )
  );

  // ----------------------------------------------------------
  // Debug
  // ----------------------------------------------------------
  debug_gate i_debug_gate (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .dbg_enable_i ( dbg_enable_i ),
    .debug_req_i  ( debug_req_i  ),
    .debug_req_o  ( debug_req_o  )
  );

endmodule

/* design/sram_mem.sv */
/*
  Single-port word SRAM with byte enables and registered read.
  Contents are undefined after power-up. A write to the exit address
  also merges into exit_o, which resets to zero.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module sram_mem (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   sel_i,
  input  soc_pkg::bus_req_t      req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic [`SOC_DATA_W-1:0] exit_o
);

  localparam int unsigned off_lsb = $clog2(`SOC_BE_W);
  localparam int unsigned idx_w   = $clog2(`SOC_SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_SRAM_WORDS];
  logic [`SOC_ADDR_W-1:0] offset;
  logic [idx_w-1:0]       idx;
  logic                   wr_en;
  logic                   exit_hit;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [`SOC_DATA_W-1:0] exit_q;

  // Byte-lane merge of new data into an old word
  function automatic logic [`SOC_DATA_W-1:0] merge_be(
    input logic [`SOC_DATA_W-1:0] old_w,
    input logic [`SOC_DATA_W-1:0] new_w,
    input logic [`SOC_BE_W-1:0]   be
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < `SOC_BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset   = req_i.addr - `SOC_DRAM_BASE;
  assign idx      = offset[off_lsb +: idx_w];
  assign wr_en    = sel_i && (req_i.op == soc_pkg::OP_WRITE);
  assign exit_hit = wr_en && (req_i.addr == `SOC_EXIT_ADDR);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[idx] <= merge_be(mem_q[idx], req_i.wdata, req_i.be);
    end
    if (sel_i) begin
      // Writes answer with zero data
      rdata_q <= (req_i.op == soc_pkg::OP_READ) ? mem_q[idx] : '0;
    end
  end

  assign rdata_o = rdata_q;

  // ----------------------------------------------------------
  // Exit register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_hit) begin
      exit_q <= merge_be(exit_q, req_i.wdata, req_i.be);
    end
  end

  assign exit_o = exit_q;

endmodule

/* verif/soc_tb_model.svh */
/*
  Reference model of the memory subsystem, included inside the testbench.
  Tracks SRAM contents and the exit word; word addresses only.
*/
`ifndef SOC_TB_MODEL_SVH
`define SOC_TB_MODEL_SVH

logic [`SOC_DATA_W-1:0] model_mem [`SOC_SRAM_WORDS];
bit                     model_written [`SOC_SRAM_WORDS];
logic [`SOC_DATA_W-1:0] model_exit;

// Target region by address map and op
function automatic soc_pkg::region_e model_region(input soc_pkg::bus_req_t req);
  soc_pkg::region_e region;
  region = soc_pkg::REG_NONE;
  if (req.addr >= `SOC_DRAM_BASE &&
      req.addr < `SOC_DRAM_BASE + `SOC_SRAM_WORDS * `SOC_BE_W) begin
    region = soc_pkg::REG_SRAM;
  end else if (req.addr >= `SOC_ROM_BASE &&
               req.addr < `SOC_ROM_BASE + `SOC_ROM_WORDS * `SOC_BE_W &&
               req.op == soc_pkg::OP_READ) begin
    region = soc_pkg::REG_ROM;   // Writes to ROM fall through to an error
  end
  return region;
endfunction

// One mask bit per data bit, taken from its byte enable
function automatic logic [`SOC_DATA_W-1:0] lane_mask(input logic [`SOC_BE_W-1:0] be);
  logic [`SOC_DATA_W-1:0] m;
  for (int i = 0; i < `SOC_DATA_W; i++) begin
    m[i] = be[i / 8];
  end
  return m;
endfunction

// Applies one request to the model and gives the expected response
function automatic soc_pkg::bus_rsp_t model_access(input soc_pkg::bus_req_t req);
  soc_pkg::bus_rsp_t      rsp;
  logic [`SOC_DATA_W-1:0] m;
  int unsigned            idx;
  rsp.rdata = '0;
  rsp.resp  = soc_pkg::RESP_OKAY;
  m         = lane_mask(req.be);
  case (model_region(req))
    soc_pkg::REG_ROM: begin
      rsp.rdata = soc_pkg::rom_image[(req.addr - `SOC_ROM_BASE) / `SOC_BE_W];
    end
    soc_pkg::REG_SRAM: begin
      idx = (req.addr - `SOC_DRAM_BASE) / `SOC_BE_W;
      if (req.op == soc_pkg::OP_WRITE) begin
        model_mem[idx]     = (model_mem[idx] & ~m) | (req.wdata & m);
        model_written[idx] = 1'b1;
        if (req.addr == `SOC_EXIT_ADDR) begin
          model_exit = (model_exit & ~m) | (req.wdata & m);
        end
      end else begin
        rsp.rdata = model_mem[idx];
      end
    end
    default: rsp.resp = soc_pkg::RESP_DECERR;   // Unmapped or ROM write
  endcase
  return rsp;
endfunction

`endif

/* verif/soc_tb.sv */
/*
  Random-stimulus testbench for soc_top with a fixed seed.
  One request in flight at a time; results checked against the model.
*/
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_tb;

  localparam int N_ROM  = 16;
  localparam int N_SRAM = 200;
  localparam int N_ERR  = 24;
  localparam int N_BP   = 30;
  localparam int N_EXIT = 8;
  localparam int N_REQ  = N_ROM + N_SRAM + 2 * N_ERR + N_BP + N_EXIT;  // Errors add read-backs
  localparam int LIMIT  = 20 * N_REQ + `SOC_DBG_DELAY;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_valid_i;
  soc_pkg::bus_req_t        req_i;
  logic                     req_ready_o;
  logic                     rsp_valid_o;
  soc_pkg::bus_rsp_t        rsp_o;
  logic                     rsp_ready_i;
  logic [`SOC_DATA_W-1:0]   exit_o;
  logic                     dbg_enable_i;
  logic [`SOC_NB_HARTS-1:0] debug_req_i;
  logic [`SOC_NB_HARTS-1:0] debug_req_o;

  integer seed     = 10;
  int     cycles   = 0;
  int     checks   = 0;
  int     errors   = 0;
  int     tests    = 0;
  int     answered = 0;
  int     chk0;
  int     err0;
  int     written_q [$];     // SRAM words the model has written

  `include "soc_tb_model.svh"

  soc_top dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_ready_o  ( req_ready_o  ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .exit_o       ( exit_o       ),
    .dbg_enable_i ( dbg_enable_i ),
    .debug_req_i  ( debug_req_i  ),
    .debug_req_o  ( debug_req_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Response handshakes seen on the master port; inputs only move on rising edges
  always @(negedge clk_i) begin
    if (rst_ni && rsp_valid_o && rsp_ready_i) answered++;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic compare(input string name, input logic [`SOC_DATA_W:0] exp_v,
                         input logic [`SOC_DATA_W:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic start_test();
    chk0 = checks;
    err0 = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%-12s %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  function automatic soc_pkg::bus_req_t make_req(input soc_pkg::bus_op_e op,
                                                 input logic [`SOC_ADDR_W-1:0] addr);
    soc_pkg::bus_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = {$random(seed), $random(seed)};
    r.be    = $random(seed);
    return r;
  endfunction

  function automatic logic [`SOC_ADDR_W-1:0] sram_addr(input int idx);
    return `SOC_DRAM_BASE + idx * `SOC_BE_W;
  endfunction

  function automatic int written_word();
    return written_q[$unsigned($random(seed)) % written_q.size()];
  endfunction

  task automatic send_req(input soc_pkg::bus_req_t r);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= r;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);                 // Transfer on this edge
    req_valid_i <= 1'b0;
  endtask

  // Waits for the response, stalls it, then takes it
  task automatic take_rsp(input string name, input int stall, output soc_pkg::bus_rsp_t r);
    @(negedge clk_i);
    while (!rsp_valid_o) @(negedge clk_i);
    r = rsp_o;
    repeat (stall) begin
      @(negedge clk_i);
      compare({name, " held rsp"}, r, rsp_o);
      compare({name, " held valid"}, 1, rsp_valid_o);
      compare({name, " req_ready"}, 0, req_ready_o);
    end
    @(posedge clk_i);
    rsp_ready_i <= 1'b1;
    @(negedge clk_i);
    compare({name, " valid"}, 1, rsp_valid_o);
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
    @(negedge clk_i);
    compare({name, " duplicate"}, 0, rsp_valid_o);
  endtask

  task automatic run_xfer(input string name, input soc_pkg::bus_req_t r, input int stall);
    soc_pkg::bus_rsp_t exp_rsp;
    soc_pkg::bus_rsp_t got;
    if (model_region(r) == soc_pkg::REG_SRAM && r.op == soc_pkg::OP_WRITE &&
        !model_written[(r.addr - `SOC_DRAM_BASE) / `SOC_BE_W]) begin
      written_q.push_back((r.addr - `SOC_DRAM_BASE) / `SOC_BE_W);
    end
    exp_rsp = model_access(r);
    send_req(r);
    take_rsp(name, stall, got);
    compare(name, exp_rsp, got);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    soc_pkg::bus_req_t        r;
    logic [`SOC_NB_HARTS-1:0] dreq;
    logic                     en;
    int                       ans0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_ready_i  = 1'b0;
    dbg_enable_i = 1'b0;
    debug_req_i  = '0;
    model_exit   = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test();
    @(negedge clk_i);
    compare("reset req_ready", 1, req_ready_o);
    compare("reset rsp_valid", 0, rsp_valid_o);
    compare("reset exit", 0, exit_o);
    for (int i = 0; i < 10; i++) begin     // Inside the quiet window
      @(posedge clk_i);
      dbg_enable_i <= 1'b1;
      debug_req_i  <= $random(seed);
      @(negedge clk_i);
      compare("debug window", 0, debug_req_o);
    end
    repeat (20) @(posedge clk_i);
    for (int i = 0; i < 20; i++) begin
      dreq = $random(seed);
      en   = $random(seed);
      dbg_enable_i <= en;
      debug_req_i  <= dreq;
      @(negedge clk_i);
      compare("debug pass", en ? dreq : '0, debug_req_o);
      @(posedge clk_i);
    end
    dbg_enable_i <= 1'b0;
    finish_test("debug_gate");

    start_test();
    for (int i = 0; i < N_ROM; i++) begin
      r = make_req(soc_pkg::OP_READ, `SOC_ROM_BASE +
                   ($unsigned($random(seed)) % `SOC_ROM_WORDS) * `SOC_BE_W);
      run_xfer("rom_read", r, 0);
    end
    finish_test("rom_read");

    start_test();
    for (int i = 0; i < N_SRAM; i++) begin
      if (written_q.size() > 0 && ($random(seed) & 1)) begin
        r = make_req(soc_pkg::OP_READ, sram_addr(written_word()));
      end else begin
        r = make_req(soc_pkg::OP_WRITE,
                     sram_addr($unsigned($random(seed)) % `SOC_SRAM_WORDS));
      end
      run_xfer("sram_rw", r, 0);
    end
    finish_test("sram_rw");

    start_test();
    for (int i = 0; i < N_ERR; i++) begin
      case (i % 3)
        0: r = make_req(soc_pkg::OP_WRITE, `SOC_ROM_BASE +
                        ($unsigned($random(seed)) % `SOC_ROM_WORDS) * `SOC_BE_W);
        // Just past the SRAM end, aliases onto real words if decoded wrongly
        1: r = make_req(soc_pkg::OP_WRITE, sram_addr(`SOC_SRAM_WORDS +
                        $unsigned($random(seed)) % `SOC_SRAM_WORDS));
        default: begin
          do begin
            r = make_req(soc_pkg::bus_op_e'($random(seed) & 1), $random(seed));
          end while (model_region(r) != soc_pkg::REG_NONE);
        end
      endcase
      run_xfer("decerr", r, 0);
      run_xfer("decerr readback", make_req(soc_pkg::OP_READ, sram_addr(written_word())), 0);
    end
    finish_test("decerr");

    start_test();
    ans0 = answered;
    for (int i = 0; i < N_BP; i++) begin
      case ($unsigned($random(seed)) % 3)
        0: r = make_req(soc_pkg::OP_READ, `SOC_ROM_BASE +
                        ($unsigned($random(seed)) % `SOC_ROM_WORDS) * `SOC_BE_W);
        1: r = make_req(soc_pkg::OP_WRITE,
                        sram_addr($unsigned($random(seed)) % `SOC_SRAM_WORDS));
        default: r = make_req(soc_pkg::OP_READ, sram_addr(written_word()));
      endcase
      run_xfer("backpressure", r, $unsigned($random(seed)) % 9);
    end
    @(posedge clk_i);
    compare("backpressure answered", N_BP, answered - ans0);
    finish_test("backpressure");

    start_test();
    for (int i = 0; i < N_EXIT; i++) begin
      run_xfer("exit write", make_req(soc_pkg::OP_WRITE, `SOC_EXIT_ADDR), 0);
      compare("exit value", model_exit, exit_o);
    end
    finish_test("exit");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
